//--- project.f
logic/dcache_pkg.sv
logic/dcache_stage_if.sv
logic/replay_queue_decode.sv
logic/dcache_miss_engine.sv
logic/dcache_execute.sv
logic/result_commit.sv
logic/dcache_top.sv
tests/dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f project.f

output=$(./obj_dir/Vdcache_tb 2>&1) || true
echo "$output"

if grep -qx "TEST PASSED" <<< "$output"
then
   exit 0
fi
exit 1

//--- tests/dcache_tb.sv
// Testbench for the blocking data cache with memory model, reference results and ordered checker
`timescale 1ns/10ps

module dcache_tb;

   localparam int num_req_c = 209;
   localparam int timeout_cycles_c = 40 * num_req_c + 200;

   logic                   clk_i = 1'b0;
   logic                   rst_i;
   logic                   v_i;
   dcache_pkg::dcache_op_e op_i;
   dcache_pkg::addr_t      addr_i;
   dcache_pkg::word_t      wdata_i;
   logic                   uncached_i;
   logic                   ready_o;
   dcache_pkg::word_t      data_o;
   logic                   v_o;
   logic                   mem_cmd_v_o;
   logic                   mem_cmd_write_o;
   dcache_pkg::addr_t      mem_cmd_addr_o;
   dcache_pkg::word_t      mem_cmd_data_o;
   logic                   mem_cmd_ready_i = 1'b0;
   logic                   mem_resp_v_i = 1'b0;
   dcache_pkg::word_t      mem_resp_data_i = '0;
   logic                   mem_resp_yumi_o;

   integer seed = 32'h035b8ba0;

   int error_count = 0;
   int check_count = 0;
   int accepted_count = 0;
   int result_count = 0;
   int cycle_count = 0;
   int outstanding;
   string req_name = "";

   // Memory model state
   dcache_pkg::word_t mem_store [dcache_pkg::addr_t];
   logic read_pending = 1'b0;
   int resp_count = 0;
   dcache_pkg::word_t resp_data = '0;
   int read_count = 0;
   int write_count = 0;
   dcache_pkg::addr_t last_wr_addr = '0;
   dcache_pkg::word_t last_wr_data = '0;

   // Reference memory, updated in request order
   dcache_pkg::word_t ref_store [dcache_pkg::addr_t];
   dcache_pkg::word_t exp_data_q [$];
   string exp_name_q [$];
   dcache_pkg::word_t exp_word;
   string exp_name;

   dcache_top #(.sets_p(16), .queue_els_p(dcache_pkg::queue_els_c)) dcache_top_i
     (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.v_i(v_i)
     ,.op_i(op_i)
     ,.addr_i(addr_i)
     ,.wdata_i(wdata_i)
     ,.uncached_i(uncached_i)
     ,.ready_o(ready_o)
     ,.data_o(data_o)
     ,.v_o(v_o)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_write_o(mem_cmd_write_o)
     ,.mem_cmd_addr_o(mem_cmd_addr_o)
     ,.mem_cmd_data_o(mem_cmd_data_o)
     ,.mem_cmd_ready_i(mem_cmd_ready_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_data_i(mem_resp_data_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     );

   always #4 clk_i = ~clk_i;

   // Unwritten words read as a pattern of the full address
   function automatic dcache_pkg::word_t init_word(input dcache_pkg::addr_t a);
      return {a ^ 16'h5a3c, ~a};
   endfunction

   function automatic dcache_pkg::word_t mem_word(input dcache_pkg::addr_t a);
      if (mem_store.exists(a))
         return mem_store[a];
      return init_word(a);
   endfunction

   function automatic dcache_pkg::word_t expected_data(input dcache_pkg::dcache_op_e op,
                                                       input dcache_pkg::addr_t a);
      if (op == dcache_pkg::op_store)
         return '0;
      if (ref_store.exists(a))
         return ref_store[a];
      return init_word(a);
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      assert (actual == expected)
      else
      begin
         error_count++;
         $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic send_req(input dcache_pkg::dcache_op_e op, input dcache_pkg::addr_t addr,
                           input dcache_pkg::word_t wdata, input logic uncached,
                           input string name);
      v_i        = 1'b1;
      op_i       = op;
      addr_i     = addr;
      wdata_i    = wdata;
      uncached_i = uncached;
      req_name   = name;
      while (!ready_o)
      begin
         @(posedge clk_i);
         #1;
      end
      @(posedge clk_i);
      #1;
      v_i = 1'b0;
   endtask

   // Wait for all results and for the memory side to go quiet
   task automatic drain();
      do
      begin
         @(posedge clk_i);
         #1;
      end
      while (result_count != accepted_count || mem_cmd_v_o || read_pending);
   endtask

   // Memory model with command stalls and variable response latency
   always @(posedge clk_i)
   begin
      if (rst_i)
      begin
         read_pending = 1'b0;
         resp_count   = 0;
      end
      else
      begin
         if (mem_resp_v_i && mem_resp_yumi_o)
            read_pending = 1'b0;
         if (mem_cmd_v_o && mem_cmd_ready_i)
         begin
            if (mem_cmd_write_o)
            begin
               mem_store[mem_cmd_addr_o] = mem_cmd_data_o;
               last_wr_addr = mem_cmd_addr_o;
               last_wr_data = mem_cmd_data_o;
               write_count++;
            end
            else
            begin
               check_count++;
               assert (!read_pending)
               else
               begin
                  error_count++;
                  $display("memory got a second read command before answering the first");
               end
               read_pending = 1'b1;
               read_count++;
               resp_data  = mem_word(mem_cmd_addr_o);
               resp_count = 1 + int'($unsigned($random(seed)) % 6);
            end
         end
         else if (read_pending && resp_count > 0)
            resp_count--;
      end
      #1;
      mem_cmd_ready_i = ($unsigned($random(seed)) % 4) != 0;
      mem_resp_v_i    = read_pending && (resp_count == 0);
      mem_resp_data_i = read_pending ? resp_data : '0;
   end

   // Checker for results, request order and queue back-pressure
   always @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         outstanding = accepted_count - result_count;
         check_value("ready_o against uncommitted count",
                     32'(outstanding != dcache_pkg::queue_els_c), 32'(ready_o));
         if (v_o)
         begin
            check_count++;
            assert (exp_data_q.size() > 0)
            else
            begin
               error_count++;
               $display("result came out with no request outstanding");
            end
            if (exp_data_q.size() > 0)
            begin
               exp_word = exp_data_q.pop_front();
               exp_name = exp_name_q.pop_front();
               check_value(exp_name, exp_word, data_o);
            end
            result_count++;
         end
         if (v_i && ready_o)
         begin
            exp_data_q.push_back(expected_data(op_i, addr_i));
            exp_name_q.push_back(req_name);
            if (op_i == dcache_pkg::op_store)
               ref_store[addr_i] = wdata_i;
            accepted_count++;
         end
      end
   end

   always @(posedge clk_i)
   begin
      cycle_count++;
      if (cycle_count >= timeout_cycles_c)
      begin
         $display("timeout after %0d cycles with %0d of %0d results out",
                  cycle_count, result_count, accepted_count);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial
   begin
      int unsigned r;
      int reads_before;
      int writes_before;
      dcache_pkg::addr_t a;
      rst_i      = 1'b1;
      v_i        = 1'b0;
      op_i       = dcache_pkg::op_load;
      addr_i     = '0;
      wdata_i    = '0;
      uncached_i = 1'b0;
      repeat (2) @(posedge clk_i);
      #1;
      rst_i = 1'b0;

      // Idle outputs after reset, ready high
      repeat (4)
      begin
         @(posedge clk_i);
         #1;
         check_value("reset idle outputs", 32'h1,
                     32'({v_o, mem_cmd_v_o, mem_resp_yumi_o, ready_o}));
      end

      reads_before  = read_count;
      writes_before = write_count;
      send_req(dcache_pkg::op_load, 16'h0123, '0, 1'b0, "load miss");
      drain();
      check_value("load miss reads", 32'(reads_before + 1), 32'(read_count));
      send_req(dcache_pkg::op_load, 16'h0123, '0, 1'b0, "load hit");
      drain();
      check_value("load hit reads", 32'(reads_before + 1), 32'(read_count));
      check_value("load writes", 32'(writes_before), 32'(write_count));

      // Write-through store, then cached and uncached loads of it
      writes_before = write_count;
      send_req(dcache_pkg::op_store, 16'h0123, 32'hc0de_0123, 1'b0, "store");
      drain();
      check_value("store writes", 32'(writes_before + 1), 32'(write_count));
      check_value("store address", 32'h0000_0123, 32'(last_wr_addr));
      check_value("store data", 32'hc0de_0123, last_wr_data);
      send_req(dcache_pkg::op_load, 16'h0123, '0, 1'b0, "load after store");
      send_req(dcache_pkg::op_load, 16'h0123, '0, 1'b1, "uncached load after store");
      drain();

      reads_before = read_count;
      send_req(dcache_pkg::op_load, 16'h0456, '0, 1'b1, "uncached load");
      send_req(dcache_pkg::op_load, 16'h0456, '0, 1'b1, "uncached repeat");
      send_req(dcache_pkg::op_store, 16'h0456, 32'h1234_5678, 1'b0, "store between");
      send_req(dcache_pkg::op_load, 16'h0456, '0, 1'b1, "uncached after store");
      drain();
      check_value("uncached reads", 32'(reads_before + 3), 32'(read_count));

      // Mixed stream over a small address pool so sets conflict
      for (int n = 0; n < 200; n++)
      begin
         r = $unsigned($random(seed));
         a = {10'h000, r[21:16]};
         send_req((r[1:0] == 2'd0) ? dcache_pkg::op_store : dcache_pkg::op_load, a,
                  dcache_pkg::word_t'($random(seed)), r[3:2] == 2'd0,
                  $sformatf("random %0d", n));
         if (r[7:5] == 3'd0)
         begin
            @(posedge clk_i);
            #1;
         end
      end
      drain();

      $display("checks %0d errors %0d results %0d", check_count, error_count, result_count);
      if (error_count == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- logic/dcache_top.sv
// Blocking data cache top with replay queue, cache execute and result stages
`timescale 1ns/10ps

module dcache_top
  #(parameter int sets_p = 16
   , parameter int queue_els_p = dcache_pkg::queue_els_c)
   ( input                          clk_i
   , input                          rst_i

   , input                          v_i
   , input dcache_pkg::dcache_op_e  op_i
   , input dcache_pkg::addr_t       addr_i
   , input dcache_pkg::word_t       wdata_i
   , input                          uncached_i
   , output logic                   ready_o

   , output dcache_pkg::word_t      data_o
   , output logic                   v_o

   , output logic                   mem_cmd_v_o
   , output logic                   mem_cmd_write_o
   , output dcache_pkg::addr_t      mem_cmd_addr_o
   , output dcache_pkg::word_t      mem_cmd_data_o
   , input                          mem_cmd_ready_i

   , input                          mem_resp_v_i
   , input dcache_pkg::word_t       mem_resp_data_i
   , output logic                   mem_resp_yumi_o
   );

   dcache_stage_if stage_if ();
   commit_if       cmt_if ();

   logic commit_lo;
   logic rollback_lo;
   logic pipe_v1_r;
   logic pipe_v2_r;

   // Tracks which pipe slots hold a live request
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         pipe_v1_r <= 1'b0;
         pipe_v2_r <= 1'b0;
      end
      else
      begin
         pipe_v1_r <= stage_if.valid & stage_if.ready & ~rollback_lo;
         pipe_v2_r <= pipe_v1_r & ~rollback_lo;
      end
   end

   replay_queue_decode #(.queue_els_p(queue_els_p)) decode
     (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.v_i(v_i)
     ,.op_i(op_i)
     ,.addr_i(addr_i)
     ,.wdata_i(wdata_i)
     ,.uncached_i(uncached_i)
     ,.ready_o(ready_o)
     ,.commit_i(commit_lo)
     ,.rollback_i(rollback_lo)
     ,.issue(stage_if.decode)
     );

   dcache_execute #(.sets_p(sets_p)) execute
     (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.issue(stage_if.execute)
     ,.flush_i(rollback_lo)
     ,.commit(cmt_if.source)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_write_o(mem_cmd_write_o)
     ,.mem_cmd_addr_o(mem_cmd_addr_o)
     ,.mem_cmd_data_o(mem_cmd_data_o)
     ,.mem_cmd_ready_i(mem_cmd_ready_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_data_i(mem_resp_data_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     );

   result_commit result
     (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.commit(cmt_if.sink)
     ,.stage2_v_i(pipe_v2_r)
     ,.data_o(data_o)
     ,.v_o(v_o)
     ,.commit_o(commit_lo)
     ,.rollback_o(rollback_lo)
     );

endmodule

//--- logic/result_commit.sv
// Result stage, formats load and store results and raises poison when stage 2 did not complete
`timescale 1ns/10ps

module result_commit
   ( input                       clk_i
   , input                       rst_i

   , commit_if.sink              commit
   , input                       stage2_v_i

   , output dcache_pkg::word_t   data_o
   , output logic                v_o

   , output logic                commit_o
   , output logic                rollback_o
   );

   // Stores complete with a zero word
   assign data_o   = commit.is_store ? '0 : commit.rdata;
   assign v_o      = commit.hit_v;
   assign commit_o = commit.hit_v;

   // Valid in stage 2 with no result, so the request must replay
   assign rollback_o = stage2_v_i & ~commit.hit_v;

   // Poison flushes the pipe, so the next stage 2 slot is empty
   no_back_to_back_poison_a: assert property (@(posedge clk_i) disable iff (rst_i)
      rollback_o |=> !rollback_o);

endmodule

//--- logic/dcache_execute.sv
// Cache execute stage with two-stage tag and data lookup, hit decision and miss engine
`timescale 1ns/10ps

module dcache_execute
  #(parameter int sets_p = 16)
   ( input                       clk_i
   , input                       rst_i

   , dcache_stage_if.execute     issue
   , input                       flush_i
   , commit_if.source            commit

   , output logic                mem_cmd_v_o
   , output logic                mem_cmd_write_o
   , output dcache_pkg::addr_t   mem_cmd_addr_o
   , output dcache_pkg::word_t   mem_cmd_data_o
   , input                       mem_cmd_ready_i

   , input                       mem_resp_v_i
   , input dcache_pkg::word_t    mem_resp_data_i
   , output logic                mem_resp_yumi_o
   );

   localparam int index_bits_lp = $clog2(sets_p);

   logic              line_v_r [sets_p];
   dcache_pkg::addr_t tag_r [sets_p];
   dcache_pkg::word_t data_r [sets_p];

   logic s1_v_r, s2_v_r;
   dcache_pkg::dcache_op_e s1_op_r, s2_op_r;
   dcache_pkg::addr_t s1_addr_r, s2_addr_r;
   dcache_pkg::word_t s1_wdata_r, s2_wdata_r;
   logic s1_uncached_r, s2_uncached_r;
   logic s2_line_v_r;
   dcache_pkg::addr_t s2_tag_r;
   dcache_pkg::word_t s2_data_r;

   // One-entry buffer for uncached load data
   logic bypass_v_r;
   dcache_pkg::addr_t bypass_addr_r;
   dcache_pkg::word_t bypass_data_r;
   logic fill_uncached_r;

   logic busy;
   logic fill_v;
   dcache_pkg::addr_t fill_addr;
   dcache_pkg::word_t fill_data;
   logic is_store, tag_hit, bypass_hit, done;
   logic start_write, start_read;
   logic store_wr, fill_wr, line_we, fwd;
   logic [index_bits_lp-1:0] s1_idx, s2_idx, fill_idx, line_idx;
   dcache_pkg::addr_t line_tag;
   dcache_pkg::word_t line_data;

   assign s1_idx   = index_bits_lp'(dcache_pkg::index_of(s1_addr_r, index_bits_lp));
   assign s2_idx   = index_bits_lp'(dcache_pkg::index_of(s2_addr_r, index_bits_lp));
   assign fill_idx = index_bits_lp'(dcache_pkg::index_of(fill_addr, index_bits_lp));

   // No issue while a memory operation is in flight
   assign issue.ready = ~busy;

   // Stage 2 decision
   assign is_store    = (s2_op_r == dcache_pkg::op_store);
   assign tag_hit     = s2_line_v_r && (s2_tag_r == dcache_pkg::tag_of(s2_addr_r, index_bits_lp));
   assign bypass_hit  = bypass_v_r && (bypass_addr_r == s2_addr_r);
   assign done        = s2_v_r & (is_store ? ~busy : (s2_uncached_r ? bypass_hit : tag_hit));
   assign start_write = s2_v_r & is_store & ~busy;
   assign start_read  = s2_v_r & ~is_store & ~done & ~busy;

   assign commit.hit_v    = done;
   assign commit.is_store = is_store;
   assign commit.rdata    = s2_uncached_r ? bypass_data_r : s2_data_r;

   // Single line write port shared by store hits and cached fills
   assign store_wr  = start_write & tag_hit;
   assign fill_wr   = fill_v & ~fill_uncached_r;
   assign line_we   = store_wr | fill_wr;
   assign line_idx  = fill_wr ? fill_idx : s2_idx;
   assign line_tag  = dcache_pkg::tag_of(fill_wr ? fill_addr : s2_addr_r, index_bits_lp);
   assign line_data = fill_wr ? fill_data : s2_wdata_r;
   assign fwd       = line_we && (line_idx == s1_idx);

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         s1_v_r     <= 1'b0;
         s2_v_r     <= 1'b0;
         bypass_v_r <= 1'b0;
         for (int i = 0; i < sets_p; i++)
            line_v_r[i] <= 1'b0;
      end
      else
      begin
         s1_v_r <= issue.valid & issue.ready & ~flush_i;
         s2_v_r <= s1_v_r & ~flush_i;
         if (line_we)
            line_v_r[line_idx] <= 1'b1;
         if (fill_v && fill_uncached_r)
            bypass_v_r <= 1'b1;
         else if (done && s2_uncached_r && !is_store)
            bypass_v_r <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      s1_op_r       <= issue.op;
      s1_addr_r     <= issue.addr;
      s1_wdata_r    <= issue.wdata;
      s1_uncached_r <= issue.uncached;
      s2_op_r       <= s1_op_r;
      s2_addr_r     <= s1_addr_r;
      s2_wdata_r    <= s1_wdata_r;
      s2_uncached_r <= s1_uncached_r;
      // Line being written this cycle overrides the array read
      s2_line_v_r   <= fwd ? 1'b1 : line_v_r[s1_idx];
      s2_tag_r      <= fwd ? line_tag : tag_r[s1_idx];
      s2_data_r     <= fwd ? line_data : data_r[s1_idx];
      if (line_we)
      begin
         tag_r[line_idx]  <= line_tag;
         data_r[line_idx] <= line_data;
      end
      if (start_read)
         fill_uncached_r <= s2_uncached_r;
      if (fill_v && fill_uncached_r)
      begin
         bypass_addr_r <= fill_addr;
         bypass_data_r <= fill_data;
      end
   end

   dcache_miss_engine miss_engine
     (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.start_write_i(start_write)
     ,.start_read_i(start_read)
     ,.addr_i(s2_addr_r)
     ,.wdata_i(s2_wdata_r)
     ,.busy_o(busy)
     ,.fill_v_o(fill_v)
     ,.fill_addr_o(fill_addr)
     ,.fill_data_o(fill_data)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_write_o(mem_cmd_write_o)
     ,.mem_cmd_addr_o(mem_cmd_addr_o)
     ,.mem_cmd_data_o(mem_cmd_data_o)
     ,.mem_cmd_ready_i(mem_cmd_ready_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_data_i(mem_resp_data_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     );

   // Poison only for a live stage 2 request that did not finish
   flush_only_on_incomplete_a: assert property (@(posedge clk_i) disable iff (rst_i)
      flush_i |-> (s2_v_r && !done));

endmodule

//--- logic/dcache_miss_engine.sv
// Miss engine, sequences memory commands for fills, write-through stores and uncached loads
`timescale 1ns/10ps

module dcache_miss_engine
   ( input                       clk_i
   , input                       rst_i

   , input                       start_write_i
   , input                       start_read_i
   , input dcache_pkg::addr_t    addr_i
   , input dcache_pkg::word_t    wdata_i

   , output logic                busy_o
   , output logic                fill_v_o
   , output dcache_pkg::addr_t   fill_addr_o
   , output dcache_pkg::word_t   fill_data_o

   , output logic                mem_cmd_v_o
   , output logic                mem_cmd_write_o
   , output dcache_pkg::addr_t   mem_cmd_addr_o
   , output dcache_pkg::word_t   mem_cmd_data_o
   , input                       mem_cmd_ready_i

   , input                       mem_resp_v_i
   , input dcache_pkg::word_t    mem_resp_data_i
   , output logic                mem_resp_yumi_o
   );

   dcache_pkg::miss_state_e state_r;
   dcache_pkg::addr_t cmd_addr_r;
   dcache_pkg::word_t cmd_data_r;

   assign busy_o          = (state_r != dcache_pkg::ms_idle);
   assign mem_cmd_v_o     = (state_r == dcache_pkg::ms_write_cmd)
                          | (state_r == dcache_pkg::ms_read_cmd);
   assign mem_cmd_write_o = (state_r == dcache_pkg::ms_write_cmd);
   assign mem_cmd_addr_o  = cmd_addr_r;
   assign mem_cmd_data_o  = cmd_data_r;
   assign mem_resp_yumi_o = (state_r == dcache_pkg::ms_read_resp) & mem_resp_v_i;

   // Fill goes straight out in the cycle the response is taken
   assign fill_v_o    = mem_resp_yumi_o;
   assign fill_addr_o = cmd_addr_r;
   assign fill_data_o = mem_resp_data_i;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         state_r <= dcache_pkg::ms_idle;
      else
      begin
         case (state_r)
            dcache_pkg::ms_idle:
               if (start_write_i)
                  state_r <= dcache_pkg::ms_write_cmd;
               else if (start_read_i)
                  state_r <= dcache_pkg::ms_read_cmd;
            dcache_pkg::ms_write_cmd:
               if (mem_cmd_ready_i)
                  state_r <= dcache_pkg::ms_idle;
            dcache_pkg::ms_read_cmd:
               if (mem_cmd_ready_i)
                  state_r <= dcache_pkg::ms_read_resp;
            default:
               if (mem_resp_v_i)
                  state_r <= dcache_pkg::ms_idle;
         endcase
      end
   end

   // Command fields hold steady until the transfer
   always_ff @(posedge clk_i)
   begin
      if (!busy_o && (start_write_i || start_read_i))
      begin
         cmd_addr_r <= addr_i;
         cmd_data_r <= wdata_i;
      end
   end

   no_start_while_busy_a: assert property (@(posedge clk_i) disable iff (rst_i)
      (start_write_i || start_read_i) |-> !busy_o);

endmodule

//--- logic/replay_queue_decode.sv
// Replay queue, holds every request until it commits and reissues from the oldest on rollback
`timescale 1ns/10ps

module replay_queue_decode
  #(parameter int queue_els_p = 8)
   ( input                          clk_i
   , input                          rst_i

   , input                          v_i
   , input dcache_pkg::dcache_op_e  op_i
   , input dcache_pkg::addr_t       addr_i
   , input dcache_pkg::word_t       wdata_i
   , input                          uncached_i
   , output logic                   ready_o

   , input                          commit_i
   , input                          rollback_i

   , dcache_stage_if.decode         issue
   );

   localparam int lg_els_lp = $clog2(queue_els_p);
   localparam int ptr_w_lp = lg_els_lp + 1;
   localparam logic [ptr_w_lp-1:0] els_lp = ptr_w_lp'(queue_els_p);

   // Payload storage
   dcache_pkg::dcache_op_e op_mem [queue_els_p];
   dcache_pkg::addr_t      addr_mem [queue_els_p];
   dcache_pkg::word_t      wdata_mem [queue_els_p];
   logic                   uncached_mem [queue_els_p];

   // Extra wrap bit on each pointer tells full from empty
   logic [ptr_w_lp-1:0] wr_ptr_r;
   logic [ptr_w_lp-1:0] iss_ptr_r;
   logic [ptr_w_lp-1:0] cmt_ptr_r;
   logic [ptr_w_lp-1:0] used;
   logic [lg_els_lp-1:0] wr_idx;
   logic [lg_els_lp-1:0] iss_idx;
   logic enq;
   logic deq;

   assign used    = wr_ptr_r - cmt_ptr_r;
   assign ready_o = (used != els_lp);
   assign enq     = v_i & ready_o;
   assign wr_idx  = wr_ptr_r[lg_els_lp-1:0];
   assign iss_idx = iss_ptr_r[lg_els_lp-1:0];

   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         op_mem[wr_idx]       <= op_i;
         addr_mem[wr_idx]     <= addr_i;
         wdata_mem[wr_idx]    <= wdata_i;
         uncached_mem[wr_idx] <= uncached_i;
      end
   end

   // Next unissued entry goes out to execute
   assign issue.valid    = (iss_ptr_r != wr_ptr_r);
   assign issue.op       = op_mem[iss_idx];
   assign issue.addr     = addr_mem[iss_idx];
   assign issue.wdata    = wdata_mem[iss_idx];
   assign issue.uncached = uncached_mem[iss_idx];
   assign deq            = issue.valid & issue.ready;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         wr_ptr_r  <= '0;
         iss_ptr_r <= '0;
         cmt_ptr_r <= '0;
      end
      else
      begin
         if (enq)
            wr_ptr_r <= wr_ptr_r + 1'b1;
         // Rollback wins over an issue in the same cycle
         if (rollback_i)
            iss_ptr_r <= cmt_ptr_r;
         else if (deq)
            iss_ptr_r <= iss_ptr_r + 1'b1;
         if (commit_i)
            cmt_ptr_r <= cmt_ptr_r + 1'b1;
      end
   end

   commit_rollback_excl_a: assert property (@(posedge clk_i) disable iff (rst_i)
      !(commit_i && rollback_i));

   no_overflow_a: assert property (@(posedge clk_i) disable iff (rst_i)
      used <= els_lp);

endmodule

//--- logic/dcache_stage_if.sv
// Pipeline interfaces, issued request from decode to execute and completion from execute to result
`timescale 1ns/10ps

interface dcache_stage_if;
   logic                   valid;
   dcache_pkg::dcache_op_e op;
   dcache_pkg::addr_t      addr;
   dcache_pkg::word_t      wdata;
   logic                   uncached;
   logic                   ready;

   modport decode (output valid, output op, output addr, output wdata, output uncached,
                   input ready);
   modport execute (input valid, input op, input addr, input wdata, input uncached,
                    output ready);
endinterface

interface commit_if;
   logic              hit_v;
   logic              is_store;
   dcache_pkg::word_t rdata;

   modport source (output hit_v, output is_store, output rdata);
   modport sink (input hit_v, input is_store, input rdata);
endinterface

//--- logic/dcache_pkg.sv
// Data cache package with word and address types, opcodes, miss states and address split
package dcache_pkg;

   localparam int addr_width_c = 16;
   localparam int word_width_c = 32;

   // Replay queue depth used by default at the top level
   localparam int queue_els_c = 8;

   // Word address, low bits index the set
   typedef logic [addr_width_c-1:0] addr_t;
   typedef logic [word_width_c-1:0] word_t;

   typedef enum logic
   {
      op_load,
      op_store
   } dcache_op_e;

   typedef enum logic [1:0]
   {
      ms_idle,
      ms_write_cmd,
      ms_read_cmd,
      ms_read_resp
   } miss_state_e;

   function automatic addr_t index_of(input addr_t addr, input int index_bits);
      addr_t mask;
      mask = (addr_t'(1) << index_bits) - addr_t'(1);
      return addr & mask;
   endfunction

   function automatic addr_t tag_of(input addr_t addr, input int index_bits);
      return addr >> index_bits;
   endfunction

endpackage
